//--- common/ctrl_pkg.sv
package ctrl_pkg;

    typedef enum logic [3:0] {
        S_IDLE,
        S_OPCODE_READ,
        S_ADR_READ,
        S_ABS_LB,
        S_ABS_HB,
        S_DATA_LATCH,
        S_ALU_FINAL,
        S_ALU_TMX,
        S_DBUF_OUTPUT,
        S_PC_LOAD,
        S_BRANCH_CHECK
    } seq_state_e;

    typedef enum logic [4:0] {
        ALU_NOP = 5'd0,
        ALU_AND = 5'd1,
        ALU_OR  = 5'd2,
        ALU_XOR = 5'd3,
        ALU_ADD = 5'd4,
        ALU_FLG = 5'd5,  // Pass operand through to set Z and N
        ALU_TMX = 5'd6   // Move ALU result onto the bus
    } alu_op_e;

    typedef enum logic [2:0] {
        PC_IDLE        = 3'd0,
        PC_INC_ONE     = 3'd1,
        PC_LOAD        = 3'd2,
        PC_TAKE_BRANCH = 3'd3
    } pc_op_e;

    typedef enum logic [1:0] {
        LATCH_IDLE  = 2'b00,
        LATCH_LOAD  = 2'b01,
        LATCH_STORE = 2'b10
    } latch_op_e;

    // Bit 2 enable, bit 1 drives the bus, bit 0 selects bus 2
    typedef enum logic [2:0] {
        REG_IDLE       = 3'b000,
        REG_LOAD_BUS1  = 3'b100,
        REG_LOAD_BUS2  = 3'b101,
        REG_STORE_BUS1 = 3'b110,
        REG_STORE_BUS2 = 3'b111
    } reg_op_e;

    typedef enum logic [1:0] {
        ADDR_PC     = 2'd0,
        ADDR_MEMORY = 2'd1,
        ADDR_ALU    = 2'd2
    } addr_sel_e;

endpackage

//--- common/decode_if.sv
`timescale 1ns/1ns

interface decode_if;

    logic [isa_pkg::DATA_WIDTH-1:0]   opcode;
    logic [isa_pkg::ADDR_WIDTH-1:0]   operand_addr;
    isa_pkg::addr_mode_e              mode;
    isa_pkg::instr_group_e            group;
    isa_pkg::reg_sel_e                reg_sel;
    ctrl_pkg::alu_op_e                alu_op;
    logic [isa_pkg::STATUS_WIDTH-1:0] flag_mask;

    modport capture (output opcode, output operand_addr);

    modport classify (input opcode, output mode, output group, output reg_sel,
                      output alu_op, output flag_mask);

    modport seq (input opcode, input operand_addr, input mode, input group,
                 input reg_sel, input alu_op, input flag_mask);

endinterface

//--- common/isa_pkg.sv
package isa_pkg;

    localparam int DATA_WIDTH   = 8;
    localparam int ADDR_WIDTH   = 16;
    localparam int STATUS_WIDTH = 7;

    localparam int FLAG_C = 0;  // Carry
    localparam int FLAG_Z = 1;  // Zero
    localparam int FLAG_V = 5;  // Overflow
    localparam int FLAG_N = 6;  // Negative

    // Standard 6502 byte values
    typedef enum logic [DATA_WIDTH-1:0] {
        OP_NOP     = 8'hEA,
        OP_SEC     = 8'h38,
        OP_CLC     = 8'h18,
        OP_CLV     = 8'hB8,
        OP_TAX     = 8'hAA,
        OP_TAY     = 8'hA8,
        OP_TXA     = 8'h8A,
        OP_TYA     = 8'h98,
        OP_LDA_IMM = 8'hA9, OP_LDA_ZPG = 8'hA5, OP_LDA_ABS = 8'hAD,
        OP_LDX_IMM = 8'hA2, OP_LDX_ZPG = 8'hA6, OP_LDX_ABS = 8'hAE,
        OP_LDY_IMM = 8'hA0, OP_LDY_ZPG = 8'hA4, OP_LDY_ABS = 8'hAC,
        OP_AND_IMM = 8'h29, OP_AND_ZPG = 8'h25, OP_AND_ABS = 8'h2D,
        OP_ORA_IMM = 8'h09, OP_ORA_ZPG = 8'h05, OP_ORA_ABS = 8'h0D,
        OP_EOR_IMM = 8'h49, OP_EOR_ZPG = 8'h45, OP_EOR_ABS = 8'h4D,
        OP_ADC_IMM = 8'h69, OP_ADC_ZPG = 8'h65, OP_ADC_ABS = 8'h6D,
        OP_STA_ZPG = 8'h85, OP_STA_ABS = 8'h8D,
        OP_STX_ZPG = 8'h86, OP_STX_ABS = 8'h8E,
        OP_STY_ZPG = 8'h84, OP_STY_ABS = 8'h8C,
        OP_JMP_ABS = 8'h4C,
        OP_BCS     = 8'hB0,
        OP_BCC     = 8'h90,
        OP_BEQ     = 8'hF0,
        OP_BNE     = 8'hD0
    } opcode_e;

    typedef enum logic [2:0] {
        MODE_IMPLIED,
        MODE_IMMEDIATE,
        MODE_ZERO_PAGE,
        MODE_ABSOLUTE,
        MODE_RELATIVE
    } addr_mode_e;

    typedef enum logic [2:0] {
        GRP_NOP,
        GRP_FLAG,
        GRP_TRANSFER,
        GRP_LOAD,
        GRP_ALU,
        GRP_STORE,
        GRP_JUMP,
        GRP_BRANCH
    } instr_group_e;

    typedef enum logic [1:0] {
        REG_NONE,
        REG_A,
        REG_X,
        REG_Y
    } reg_sel_e;

endpackage

//--- decode/decode_sequencer.sv
`timescale 1ns/1ns

module decode_sequencer (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             clk_enable,
    input  logic [isa_pkg::STATUS_WIDTH-1:0] status_flags,
    decode_if.seq                            dec,
    output logic                             load_opcode,
    output logic                             load_adl,
    output logic                             load_adh,
    output logic [isa_pkg::STATUS_WIDTH-1:0] flag_write_mask,
    output logic [isa_pkg::STATUS_WIDTH-1:0] flag_value,
    output logic [isa_pkg::ADDR_WIDTH-1:0]   memory_address,
    output ctrl_pkg::addr_sel_e              address_select,
    output logic                             status_rw,
    output logic                             rw,
    output ctrl_pkg::latch_op_e              data_buffer_enable,
    output ctrl_pkg::latch_op_e              input_latch_enable,
    output ctrl_pkg::pc_op_e                 pc_enable,
    output ctrl_pkg::alu_op_e                alu_enable,
    output ctrl_pkg::reg_op_e                accumulator_enable,
    output ctrl_pkg::reg_op_e                index_x_enable,
    output ctrl_pkg::reg_op_e                index_y_enable
);

    ctrl_pkg::seq_state_e state;
    ctrl_pkg::seq_state_e next_state;
    ctrl_pkg::reg_op_e    sel_op;  // Enable for the register named by reg_sel
    isa_pkg::opcode_e     op;
    logic                 to_index;
    logic                 branch_taken;

    assign op       = isa_pkg::opcode_e'(dec.opcode);
    assign to_index = (op == isa_pkg::OP_TAX) || (op == isa_pkg::OP_TAY);

    always_comb begin
        case (op)
            isa_pkg::OP_BCS: branch_taken = status_flags[isa_pkg::FLAG_C];
            isa_pkg::OP_BCC: branch_taken = !status_flags[isa_pkg::FLAG_C];
            isa_pkg::OP_BEQ: branch_taken = status_flags[isa_pkg::FLAG_Z];
            isa_pkg::OP_BNE: branch_taken = !status_flags[isa_pkg::FLAG_Z];
            default:         branch_taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ctrl_pkg::S_IDLE;
        end else if (clk_enable) begin
            state <= next_state;
        end
    end

    // Capture happens on the edge into the named state
    assign load_opcode = (next_state == ctrl_pkg::S_OPCODE_READ);
    assign load_adl    = (next_state == ctrl_pkg::S_ADR_READ) || (next_state == ctrl_pkg::S_ABS_LB);
    assign load_adh    = (next_state == ctrl_pkg::S_ABS_HB) || (next_state == ctrl_pkg::S_PC_LOAD);

    always_comb begin
        next_state         = state;
        flag_write_mask    = '0;
        flag_value         = '0;
        memory_address     = '0;
        address_select     = ctrl_pkg::ADDR_PC;
        status_rw          = 1'b1;
        rw                 = 1'b1;
        data_buffer_enable = ctrl_pkg::LATCH_IDLE;
        input_latch_enable = ctrl_pkg::LATCH_IDLE;
        pc_enable          = ctrl_pkg::PC_IDLE;
        alu_enable         = ctrl_pkg::ALU_NOP;
        accumulator_enable = ctrl_pkg::REG_IDLE;
        index_x_enable     = ctrl_pkg::REG_IDLE;
        index_y_enable     = ctrl_pkg::REG_IDLE;
        sel_op             = ctrl_pkg::REG_IDLE;
        case (state)
            ctrl_pkg::S_IDLE: next_state = ctrl_pkg::S_OPCODE_READ;
            ctrl_pkg::S_OPCODE_READ: begin
                pc_enable = ctrl_pkg::PC_INC_ONE;
                case (dec.mode)
                    isa_pkg::MODE_IMMEDIATE, isa_pkg::MODE_RELATIVE:
                        next_state = ctrl_pkg::S_DATA_LATCH;
                    isa_pkg::MODE_ZERO_PAGE: next_state = ctrl_pkg::S_ADR_READ;
                    isa_pkg::MODE_ABSOLUTE:  next_state = ctrl_pkg::S_ABS_LB;
                    default:                 next_state = ctrl_pkg::S_IDLE;
                endcase
                if (dec.group == isa_pkg::GRP_FLAG) begin
                    flag_write_mask             = dec.flag_mask;
                    flag_value[isa_pkg::FLAG_C] = (op == isa_pkg::OP_SEC);
                end else if (dec.group == isa_pkg::GRP_TRANSFER) begin
                    sel_op = to_index ? ctrl_pkg::REG_LOAD_BUS1 : ctrl_pkg::REG_STORE_BUS1;
                    accumulator_enable = to_index ? ctrl_pkg::REG_STORE_BUS1
                                                  : ctrl_pkg::REG_LOAD_BUS1;
                end
            end
            ctrl_pkg::S_ADR_READ, ctrl_pkg::S_ABS_HB: begin
                pc_enable      = ctrl_pkg::PC_INC_ONE;
                address_select = ctrl_pkg::ADDR_MEMORY;
                memory_address = dec.operand_addr;
                next_state     = ctrl_pkg::S_DATA_LATCH;
            end
            ctrl_pkg::S_ABS_LB: begin
                pc_enable  = ctrl_pkg::PC_INC_ONE;
                next_state = (dec.group == isa_pkg::GRP_JUMP) ? ctrl_pkg::S_PC_LOAD
                                                             : ctrl_pkg::S_ABS_HB;
            end
            ctrl_pkg::S_DATA_LATCH: begin
                input_latch_enable = ctrl_pkg::LATCH_LOAD;
                if (dec.mode == isa_pkg::MODE_IMMEDIATE) begin
                    pc_enable = ctrl_pkg::PC_INC_ONE;  // Step past the operand byte
                end
                next_state = (dec.mode == isa_pkg::MODE_RELATIVE) ? ctrl_pkg::S_BRANCH_CHECK
                                                                 : ctrl_pkg::S_ALU_FINAL;
            end
            ctrl_pkg::S_ALU_FINAL: begin
                status_rw       = 1'b0;
                flag_write_mask = dec.flag_mask;
                alu_enable      = dec.alu_op;
                if (dec.group == isa_pkg::GRP_LOAD || dec.group == isa_pkg::GRP_ALU) begin
                    input_latch_enable = ctrl_pkg::LATCH_STORE;
                end
                if (dec.group == isa_pkg::GRP_ALU) begin
                    accumulator_enable = ctrl_pkg::REG_STORE_BUS2;
                end
                next_state = ctrl_pkg::S_ALU_TMX;
            end
            ctrl_pkg::S_ALU_TMX: begin
                next_state = ctrl_pkg::S_IDLE;
                if (dec.group == isa_pkg::GRP_STORE) begin
                    sel_op             = ctrl_pkg::REG_STORE_BUS2;
                    data_buffer_enable = ctrl_pkg::LATCH_LOAD;
                    next_state         = ctrl_pkg::S_DBUF_OUTPUT;
                end else if (dec.group == isa_pkg::GRP_LOAD || dec.group == isa_pkg::GRP_ALU) begin
                    sel_op     = ctrl_pkg::REG_LOAD_BUS2;
                    alu_enable = ctrl_pkg::ALU_TMX;
                end
            end
            ctrl_pkg::S_DBUF_OUTPUT: begin
                data_buffer_enable = ctrl_pkg::LATCH_STORE;
                address_select     = ctrl_pkg::ADDR_MEMORY;
                memory_address     = dec.operand_addr;
                rw                 = 1'b0;
                next_state         = ctrl_pkg::S_IDLE;
            end
            ctrl_pkg::S_PC_LOAD: begin
                pc_enable      = ctrl_pkg::PC_LOAD;
                memory_address = dec.operand_addr;
                next_state     = ctrl_pkg::S_IDLE;
            end
            ctrl_pkg::S_BRANCH_CHECK: begin
                if (branch_taken) begin
                    input_latch_enable = ctrl_pkg::LATCH_STORE;  // Offset onto the bus
                    pc_enable          = ctrl_pkg::PC_TAKE_BRANCH;
                end
                next_state = ctrl_pkg::S_IDLE;
            end
            default: next_state = ctrl_pkg::S_IDLE;
        endcase
        if (sel_op != ctrl_pkg::REG_IDLE) begin
            case (dec.reg_sel)
                isa_pkg::REG_A: accumulator_enable = sel_op;
                isa_pkg::REG_X: index_x_enable     = sel_op;
                isa_pkg::REG_Y: index_y_enable     = sel_op;
                default: ;
            endcase
        end
    end

    write_only_for_store: assert property (@(posedge clk) disable iff (!rst_n)
        !rw |-> state == ctrl_pkg::S_DBUF_OUTPUT && address_select == ctrl_pkg::ADDR_MEMORY
                && dec.group == isa_pkg::GRP_STORE);

    pc_load_only_for_jump: assert property (@(posedge clk) disable iff (!rst_n)
        pc_enable == ctrl_pkg::PC_LOAD |-> state == ctrl_pkg::S_PC_LOAD
                                           && dec.group == isa_pkg::GRP_JUMP);

endmodule

//--- decode/opcode_classifier.sv
`timescale 1ns/1ns

module opcode_classifier (
    decode_if.classify dec
);

    always_comb begin
        dec.group     = isa_pkg::GRP_NOP;
        dec.alu_op    = ctrl_pkg::ALU_NOP;
        dec.flag_mask = '0;
        case (isa_pkg::opcode_e'(dec.opcode))
            isa_pkg::OP_SEC, isa_pkg::OP_CLC: begin
                dec.group                      = isa_pkg::GRP_FLAG;
                dec.flag_mask[isa_pkg::FLAG_C] = 1'b1;
            end
            isa_pkg::OP_CLV: begin
                dec.group                      = isa_pkg::GRP_FLAG;
                dec.flag_mask[isa_pkg::FLAG_V] = 1'b1;
            end
            isa_pkg::OP_TAX, isa_pkg::OP_TAY, isa_pkg::OP_TXA, isa_pkg::OP_TYA:
                dec.group = isa_pkg::GRP_TRANSFER;
            isa_pkg::OP_LDA_IMM, isa_pkg::OP_LDA_ZPG, isa_pkg::OP_LDA_ABS,
            isa_pkg::OP_LDX_IMM, isa_pkg::OP_LDX_ZPG, isa_pkg::OP_LDX_ABS,
            isa_pkg::OP_LDY_IMM, isa_pkg::OP_LDY_ZPG, isa_pkg::OP_LDY_ABS:
                dec.group = isa_pkg::GRP_LOAD;
            isa_pkg::OP_AND_IMM, isa_pkg::OP_AND_ZPG, isa_pkg::OP_AND_ABS: begin
                dec.group  = isa_pkg::GRP_ALU;
                dec.alu_op = ctrl_pkg::ALU_AND;
            end
            isa_pkg::OP_ORA_IMM, isa_pkg::OP_ORA_ZPG, isa_pkg::OP_ORA_ABS: begin
                dec.group  = isa_pkg::GRP_ALU;
                dec.alu_op = ctrl_pkg::ALU_OR;
            end
            isa_pkg::OP_EOR_IMM, isa_pkg::OP_EOR_ZPG, isa_pkg::OP_EOR_ABS: begin
                dec.group  = isa_pkg::GRP_ALU;
                dec.alu_op = ctrl_pkg::ALU_XOR;
            end
            isa_pkg::OP_ADC_IMM, isa_pkg::OP_ADC_ZPG, isa_pkg::OP_ADC_ABS: begin
                dec.group  = isa_pkg::GRP_ALU;
                dec.alu_op = ctrl_pkg::ALU_ADD;
            end
            isa_pkg::OP_STA_ZPG, isa_pkg::OP_STA_ABS,
            isa_pkg::OP_STX_ZPG, isa_pkg::OP_STX_ABS,
            isa_pkg::OP_STY_ZPG, isa_pkg::OP_STY_ABS:
                dec.group = isa_pkg::GRP_STORE;
            isa_pkg::OP_JMP_ABS:
                dec.group = isa_pkg::GRP_JUMP;
            isa_pkg::OP_BCS, isa_pkg::OP_BCC, isa_pkg::OP_BEQ, isa_pkg::OP_BNE:
                dec.group = isa_pkg::GRP_BRANCH;
            default: ;
        endcase
        if (dec.group == isa_pkg::GRP_LOAD) begin
            dec.alu_op = ctrl_pkg::ALU_FLG;
        end
        if (dec.group == isa_pkg::GRP_LOAD || dec.group == isa_pkg::GRP_ALU) begin
            dec.flag_mask[isa_pkg::FLAG_Z] = 1'b1;
            dec.flag_mask[isa_pkg::FLAG_N] = 1'b1;
        end
    end

    // Operand form sits in bits 4:2 for every kept memory instruction
    always_comb begin
        case (dec.group)
            isa_pkg::GRP_NOP, isa_pkg::GRP_FLAG, isa_pkg::GRP_TRANSFER:
                dec.mode = isa_pkg::MODE_IMPLIED;
            isa_pkg::GRP_BRANCH:
                dec.mode = isa_pkg::MODE_RELATIVE;
            default: begin
                case (dec.opcode[4:2])
                    3'b001:  dec.mode = isa_pkg::MODE_ZERO_PAGE;
                    3'b011:  dec.mode = isa_pkg::MODE_ABSOLUTE;
                    default: dec.mode = isa_pkg::MODE_IMMEDIATE;
                endcase
            end
        endcase
    end

    always_comb begin
        dec.reg_sel = isa_pkg::REG_NONE;
        if (dec.group inside {isa_pkg::GRP_TRANSFER, isa_pkg::GRP_LOAD,
                              isa_pkg::GRP_ALU, isa_pkg::GRP_STORE}) begin
            case (dec.opcode[1:0])
                2'b01:   dec.reg_sel = isa_pkg::REG_A;
                2'b10:   dec.reg_sel = isa_pkg::REG_X;
                default: dec.reg_sel = isa_pkg::REG_Y;  // Transfers use the index register
            endcase
        end
    end

endmodule

//--- decode/operand_capture.sv
`timescale 1ns/1ns

module operand_capture (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           clk_enable,
    input  logic [isa_pkg::DATA_WIDTH-1:0] instruction,
    input  logic                           load_opcode,
    input  logic                           load_adl,
    input  logic                           load_adh,
    decode_if.capture                      cap
);

    localparam int HIGH_BITS = isa_pkg::ADDR_WIDTH - isa_pkg::DATA_WIDTH;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cap.opcode <= isa_pkg::OP_NOP;
        end else if (clk_enable && load_opcode) begin
            cap.opcode <= instruction;
        end
    end

    always_ff @(posedge clk) begin
        if (clk_enable) begin
            if (load_adl) begin
                cap.operand_addr <= {{HIGH_BITS{1'b0}}, instruction};  // Zero page until ADH
            end else if (load_adh) begin
                cap.operand_addr[isa_pkg::ADDR_WIDTH-1 -: isa_pkg::DATA_WIDTH] <= instruction;
            end
        end
    end

    one_address_byte: assert property (@(posedge clk) disable iff (!rst_n)
        !(load_adl && load_adh));

endmodule

//--- logic/instruction_decode.sv
`timescale 1ns/1ns

module instruction_decode (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             clk_enable,
    input  logic [isa_pkg::DATA_WIDTH-1:0]   instruction,
    input  logic [isa_pkg::STATUS_WIDTH-1:0] status_flags,
    output logic [isa_pkg::STATUS_WIDTH-1:0] flag_write_mask,
    output logic [isa_pkg::STATUS_WIDTH-1:0] flag_value,
    output logic [isa_pkg::ADDR_WIDTH-1:0]   memory_address,
    output ctrl_pkg::addr_sel_e              address_select,
    output logic                             status_rw,
    output logic                             rw,  // 1 read, 0 write
    output ctrl_pkg::latch_op_e              data_buffer_enable,
    output ctrl_pkg::latch_op_e              input_latch_enable,
    output ctrl_pkg::pc_op_e                 pc_enable,
    output ctrl_pkg::alu_op_e                alu_enable,
    output ctrl_pkg::reg_op_e                accumulator_enable,
    output ctrl_pkg::reg_op_e                index_x_enable,
    output ctrl_pkg::reg_op_e                index_y_enable
);

    logic load_opcode;
    logic load_adl;
    logic load_adh;

    decode_if dec ();

    opcode_classifier u_classifier (
        .dec (dec.classify)
    );

    operand_capture u_capture (
        .clk         (clk),
        .rst_n       (rst_n),
        .clk_enable  (clk_enable),
        .instruction (instruction),
        .load_opcode (load_opcode),
        .load_adl    (load_adl),
        .load_adh    (load_adh),
        .cap         (dec.capture)
    );

    decode_sequencer u_sequencer (
        .dec (dec.seq),
        .*
    );

endmodule

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
LOG=sim.log

if ! verilator --binary --timing --assert -f verilog.f \
        --top-module tb_instruction_decode -Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_instruction_decode > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Finished with errors" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi
if [ "$run_status" -ne 0 ]; then
    echo "Simulator exited with status $run_status"
    exit 1
fi
echo "Simulation passed"
exit 0

//--- tb/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- tb/tb_instruction_decode.sv
`timescale 1ns/1ns

module tb_instruction_decode;

    localparam int PROGRAM_CYCLES = 220;  // Enabled cycles of the whole program
    localparam int MAX_CYCLES     = 2 * PROGRAM_CYCLES;
    localparam logic [6:0] ZN_MASK = (7'd1 << isa_pkg::FLAG_Z) | (7'd1 << isa_pkg::FLAG_N);

    logic clk, rst_n, clk_enable, rst_q;
    logic [7:0] instruction;
    logic [6:0] status_flags, flag_write_mask, flag_value;
    logic [15:0] memory_address;
    ctrl_pkg::addr_sel_e address_select;
    logic status_rw, rw;
    ctrl_pkg::latch_op_e data_buffer_enable, input_latch_enable;
    ctrl_pkg::pc_op_e pc_enable;
    ctrl_pkg::alu_op_e alu_enable;
    ctrl_pkg::reg_op_e accumulator_enable, index_x_enable, index_y_enable;

    logic [7:0] rom [0:255];
    logic [7:0] wr_ptr, end_addr, cur_op, rand_byte;
    logic [15:0] pc, cur_pc, exp_store_addr, jmp_target;
    logic [6:0] flags, exp_fmask, exp_fvalue;
    logic [31:0] seed;
    logic started, done, outputs_idle, exp_taken, is_flag_op, is_branch;
    int step, cycles, taken_count, form, exp_cycles, alu_step;
    ctrl_pkg::alu_op_e exp_alu;

    tb_clock u_clock (.clk(clk), .rst_n(rst_n));

    instruction_decode uut (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // 0 implied, 1 immediate, 2 zero page, 3 absolute, 4 relative, 5 jump
    function automatic int form_of(input logic [7:0] op);
        case (op)
            isa_pkg::OP_LDA_IMM, isa_pkg::OP_LDX_IMM, isa_pkg::OP_LDY_IMM, isa_pkg::OP_AND_IMM,
            isa_pkg::OP_ORA_IMM, isa_pkg::OP_EOR_IMM, isa_pkg::OP_ADC_IMM: return 1;
            isa_pkg::OP_LDA_ZPG, isa_pkg::OP_LDX_ZPG, isa_pkg::OP_LDY_ZPG, isa_pkg::OP_AND_ZPG,
            isa_pkg::OP_ORA_ZPG, isa_pkg::OP_EOR_ZPG, isa_pkg::OP_ADC_ZPG,
            isa_pkg::OP_STA_ZPG, isa_pkg::OP_STX_ZPG, isa_pkg::OP_STY_ZPG: return 2;
            isa_pkg::OP_LDA_ABS, isa_pkg::OP_LDX_ABS, isa_pkg::OP_LDY_ABS, isa_pkg::OP_AND_ABS,
            isa_pkg::OP_ORA_ABS, isa_pkg::OP_EOR_ABS, isa_pkg::OP_ADC_ABS,
            isa_pkg::OP_STA_ABS, isa_pkg::OP_STX_ABS, isa_pkg::OP_STY_ABS: return 3;
            isa_pkg::OP_BCS, isa_pkg::OP_BCC, isa_pkg::OP_BEQ, isa_pkg::OP_BNE: return 4;
            isa_pkg::OP_JMP_ABS: return 5;
            default: return 0;
        endcase
    endfunction

    function automatic ctrl_pkg::alu_op_e alu_of(input logic [7:0] op);
        case (op)
            isa_pkg::OP_LDA_IMM, isa_pkg::OP_LDA_ZPG, isa_pkg::OP_LDA_ABS,
            isa_pkg::OP_LDX_IMM, isa_pkg::OP_LDX_ZPG, isa_pkg::OP_LDX_ABS,
            isa_pkg::OP_LDY_IMM, isa_pkg::OP_LDY_ZPG, isa_pkg::OP_LDY_ABS: return ctrl_pkg::ALU_FLG;
            isa_pkg::OP_AND_IMM, isa_pkg::OP_AND_ZPG, isa_pkg::OP_AND_ABS: return ctrl_pkg::ALU_AND;
            isa_pkg::OP_ORA_IMM, isa_pkg::OP_ORA_ZPG, isa_pkg::OP_ORA_ABS: return ctrl_pkg::ALU_OR;
            isa_pkg::OP_EOR_IMM, isa_pkg::OP_EOR_ZPG, isa_pkg::OP_EOR_ABS: return ctrl_pkg::ALU_XOR;
            isa_pkg::OP_ADC_IMM, isa_pkg::OP_ADC_ZPG, isa_pkg::OP_ADC_ABS: return ctrl_pkg::ALU_ADD;
            default: return ctrl_pkg::ALU_NOP;
        endcase
    endfunction

    task automatic emit(input logic [7:0] b);
        rom[wr_ptr] = b;
        wr_ptr = wr_ptr + 8'd1;
    endtask

    task automatic emit_forms(input logic [7:0] imm_op, input logic [7:0] zpg_op,
                              input logic [7:0] abs_op, input logic [7:0] base);
        emit(imm_op);
        emit(base);
        emit(zpg_op);
        emit(base + 8'd1);
        emit(abs_op);
        emit(base + 8'd2);
        emit(8'h12);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
        $display("Finished with errors");
        $fatal(1, "check failed");
    endtask

    task automatic report_failure(input string what);
        $display("At %0t ns: %s", $time, what);
        $display("Finished with errors");
        $fatal(1, "check failed");
    endtask

    initial begin
        for (int i = 0; i < 256; i++) begin
            rom[i] = 8'(i) ^ 8'h5A;
        end
        wr_ptr = 8'd0;
        emit(isa_pkg::OP_SEC);
        emit(isa_pkg::OP_CLC);
        emit(isa_pkg::OP_CLV);
        emit(isa_pkg::OP_NOP);
        emit(isa_pkg::OP_TAX);
        emit(isa_pkg::OP_TAY);
        emit(isa_pkg::OP_TXA);
        emit(isa_pkg::OP_TYA);
        emit_forms(isa_pkg::OP_LDA_IMM, isa_pkg::OP_LDA_ZPG, isa_pkg::OP_LDA_ABS, 8'h10);
        emit_forms(isa_pkg::OP_LDX_IMM, isa_pkg::OP_LDX_ZPG, isa_pkg::OP_LDX_ABS, 8'h20);
        emit_forms(isa_pkg::OP_LDY_IMM, isa_pkg::OP_LDY_ZPG, isa_pkg::OP_LDY_ABS, 8'h30);
        emit_forms(isa_pkg::OP_AND_IMM, isa_pkg::OP_AND_ZPG, isa_pkg::OP_AND_ABS, 8'h40);
        emit_forms(isa_pkg::OP_ORA_IMM, isa_pkg::OP_ORA_ZPG, isa_pkg::OP_ORA_ABS, 8'h50);
        emit_forms(isa_pkg::OP_EOR_IMM, isa_pkg::OP_EOR_ZPG, isa_pkg::OP_EOR_ABS, 8'h60);
        emit_forms(isa_pkg::OP_ADC_IMM, isa_pkg::OP_ADC_ZPG, isa_pkg::OP_ADC_ABS, 8'h70);
        emit(isa_pkg::OP_STA_ZPG);
        emit(8'h80);
        emit(isa_pkg::OP_STA_ABS);
        emit(8'h81);
        emit(8'h34);
        emit(isa_pkg::OP_STX_ZPG);
        emit(8'h82);
        emit(isa_pkg::OP_STX_ABS);
        emit(8'h83);
        emit(8'h35);
        emit(isa_pkg::OP_STY_ZPG);
        emit(8'h84);
        emit(isa_pkg::OP_STY_ABS);
        emit(8'h85);
        emit(8'h36);
        emit(isa_pkg::OP_SEC);
        // Offset bytes are refetched as NOP since taken branches are not followed
        emit(isa_pkg::OP_BCS);
        emit(isa_pkg::OP_NOP);
        emit(isa_pkg::OP_BCC);
        emit(isa_pkg::OP_NOP);
        emit(isa_pkg::OP_BEQ);
        emit(isa_pkg::OP_NOP);
        emit(isa_pkg::OP_BNE);
        emit(isa_pkg::OP_NOP);
        emit(isa_pkg::OP_JMP_ABS);
        emit(wr_ptr + 8'd4);  // Skips two filler bytes
        emit(8'h00);
        emit(8'hFF);
        emit(8'hFF);
        emit(isa_pkg::OP_NOP);
        end_addr = wr_ptr;
    end

    initial begin
        seed         = 32'h92d2_d1a1;
        rand_byte    = 8'h00;
        clk_enable   = 1'b1;
        instruction  = 8'h00;
        status_flags = '0;
    end

    // Inputs change on the falling edge
    always @(negedge clk) begin
        if (done) begin
            $display("Taken branches: %0d", taken_count);
            $display("Finished with no errors");
            $finish;
        end else begin
            seed = lcg_next(seed);
            clk_enable = (seed[31:29] != 3'd0);  // Low one cycle in eight
            rand_byte = seed[23:16];
            status_flags = flags;
            case (pc_enable)
                ctrl_pkg::PC_INC_ONE: instruction = rom[pc[7:0] + 8'd1];
                ctrl_pkg::PC_LOAD:    instruction = rom[memory_address[7:0]];
                default:              instruction = rom[pc[7:0]];
            endcase
        end
    end

    always @(posedge clk) rst_q <= rst_n;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
            cur_pc <= '0;
            cur_op <= isa_pkg::OP_NOP;
            flags <= '0;
            step <= 0;
            cycles <= 0;
            taken_count <= 0;
            started <= 1'b0;
            done <= 1'b0;
        end else if (clk_enable) begin
            cycles <= cycles + 1;
            step <= step + 1;
            if (uut.load_opcode) begin
                cur_op <= rom[pc[7:0]];
                cur_pc <= pc;
                step <= 1;
                started <= 1'b1;
                if (started && pc[7:0] == end_addr) begin
                    done <= 1'b1;
                end
            end
            case (pc_enable)
                ctrl_pkg::PC_INC_ONE:     pc <= pc + 16'd1;
                ctrl_pkg::PC_LOAD:        pc <= memory_address;
                ctrl_pkg::PC_TAKE_BRANCH: taken_count <= taken_count + 1;
                default: ;
            endcase
            if (!status_rw) begin
                flags[isa_pkg::FLAG_Z] <= (rand_byte == 8'h00);
                flags[isa_pkg::FLAG_N] <= rand_byte[7];
            end else begin
                flags <= (flags & ~flag_write_mask) | (flag_value & flag_write_mask);
            end
            if (cycles + 1 >= MAX_CYCLES) begin
                report_failure("program did not reach its end within the cycle limit");
            end
        end
    end

    always_comb begin
        form = form_of(cur_op);
        exp_alu = alu_of(cur_op);
        alu_step = form + 2;  // alu_final comes two cycles after the address bytes
        is_branch = (form == 4);
        is_flag_op = cur_op inside {isa_pkg::OP_SEC, isa_pkg::OP_CLC, isa_pkg::OP_CLV};
        exp_fmask = (cur_op == isa_pkg::OP_CLV) ? 7'd1 << isa_pkg::FLAG_V : 7'd1 << isa_pkg::FLAG_C;
        exp_fvalue = (cur_op == isa_pkg::OP_SEC) ? 7'd1 << isa_pkg::FLAG_C : 7'd0;
        exp_store_addr = (form == 3) ? {rom[cur_pc[7:0] + 8'd2], rom[cur_pc[7:0] + 8'd1]}
                                     : {8'h00, rom[cur_pc[7:0] + 8'd1]};
        jmp_target = {rom[cur_pc[7:0] + 8'd2], rom[cur_pc[7:0] + 8'd1]};
        case (cur_op)
            isa_pkg::OP_BCS: exp_taken = flags[isa_pkg::FLAG_C];
            isa_pkg::OP_BCC: exp_taken = !flags[isa_pkg::FLAG_C];
            isa_pkg::OP_BEQ: exp_taken = flags[isa_pkg::FLAG_Z];
            default:         exp_taken = !flags[isa_pkg::FLAG_Z];
        endcase
        case (form)
            1:       exp_cycles = 5;
            2:       exp_cycles = (exp_alu == ctrl_pkg::ALU_NOP) ? 7 : 6;  // Store or load/ALU
            3:       exp_cycles = (exp_alu == ctrl_pkg::ALU_NOP) ? 8 : 7;
            4, 5:    exp_cycles = 4;
            default: exp_cycles = 2;
        endcase
    end

    assign outputs_idle = pc_enable == ctrl_pkg::PC_IDLE && rw && status_rw
        && data_buffer_enable == ctrl_pkg::LATCH_IDLE && input_latch_enable == ctrl_pkg::LATCH_IDLE
        && accumulator_enable == ctrl_pkg::REG_IDLE && index_x_enable == ctrl_pkg::REG_IDLE
        && index_y_enable == ctrl_pkg::REG_IDLE && alu_enable == ctrl_pkg::ALU_NOP
        && flag_write_mask == '0;

    reset_idle: assert property (@(posedge clk) (!rst_n || !rst_q) |-> outputs_idle)
        else report_failure("a control output was active during or just after reset");

    store_address: assert property (@(posedge clk) disable iff (!rst_n)
        !rw |-> memory_address == exp_store_addr)
        else report_mismatch("memory_address", $sampled(exp_store_addr), $sampled(memory_address));

    store_select: assert property (@(posedge clk) disable iff (!rst_n)
        !rw |-> address_select == ctrl_pkg::ADDR_MEMORY)
        else report_mismatch("address_select", ctrl_pkg::ADDR_MEMORY,
                             $sampled(address_select));

    store_buffer: assert property (@(posedge clk) disable iff (!rst_n)
        !rw |-> data_buffer_enable == ctrl_pkg::LATCH_STORE)
        else report_mismatch("data_buffer_enable", ctrl_pkg::LATCH_STORE,
                             $sampled(data_buffer_enable));

    flag_mask: assert property (@(posedge clk) disable iff (!rst_n)
        step == 1 && is_flag_op |-> flag_write_mask == exp_fmask)
        else report_mismatch("flag_write_mask", $sampled(exp_fmask), $sampled(flag_write_mask));

    flag_set_value: assert property (@(posedge clk) disable iff (!rst_n)
        step == 1 && is_flag_op |-> flag_value == exp_fvalue)
        else report_mismatch("flag_value", $sampled(exp_fvalue), $sampled(flag_value));

    alu_operation: assert property (@(posedge clk) disable iff (!rst_n)
        step == alu_step && exp_alu != ctrl_pkg::ALU_NOP |-> alu_enable == exp_alu)
        else report_mismatch("alu_enable", $sampled(exp_alu), $sampled(alu_enable));

    alu_flag_mask: assert property (@(posedge clk) disable iff (!rst_n)
        step == alu_step && exp_alu != ctrl_pkg::ALU_NOP |-> flag_write_mask == ZN_MASK)
        else report_mismatch("flag_write_mask", ZN_MASK, $sampled(flag_write_mask));

    jump_target: assert property (@(posedge clk) disable iff (!rst_n)
        uut.load_opcode && started && form == 5 |-> pc == jmp_target)
        else report_mismatch("pc", $sampled(jmp_target), $sampled(pc));

    branch_decision: assert property (@(posedge clk) disable iff (!rst_n)
        step == 3 && is_branch |-> (pc_enable == ctrl_pkg::PC_TAKE_BRANCH) == exp_taken)
        else report_mismatch("pc_enable",
                             $sampled(exp_taken) ? ctrl_pkg::PC_TAKE_BRANCH : ctrl_pkg::PC_IDLE,
                             $sampled(pc_enable));

    instruction_length: assert property (@(posedge clk) disable iff (!rst_n)
        clk_enable && uut.load_opcode && started |-> step == exp_cycles)
        else report_mismatch("instruction cycles", $sampled(exp_cycles), $sampled(step));

endmodule

//--- verilog.f
common/isa_pkg.sv
common/ctrl_pkg.sv
common/decode_if.sv
decode/opcode_classifier.sv
decode/operand_capture.sv
decode/decode_sequencer.sv
logic/instruction_decode.sv
tb/tb_clock.sv
tb/tb_instruction_decode.sv
